/* common/coreTypes.sv */
package coreTypes;

    // Data path width shared by every unit
    typedef logic [31:0] word_t;

    // Register index, r0 reads zero and r15 is P
    typedef logic [3:0] regIndex_t;

    // Operation field, result is (A op B) + C
    typedef enum logic [3:0] {
        OP_OR       = 4'b0000,
        OP_AND      = 4'b0001,
        OP_ADD      = 4'b0010,
        OP_MUL      = 4'b0011, // Only op handled by the multiplier
        OP_RESERVED = 4'b0100, // Contributes nothing, result is C
        OP_SHL      = 4'b0101,
        OP_LT       = 4'b0110,
        OP_EQ       = 4'b0111,
        OP_GE       = 4'b1000,
        OP_ANDN     = 4'b1001,
        OP_XOR      = 4'b1010,
        OP_SUB      = 4'b1011,
        OP_XNOR     = 4'b1100,
        OP_SHR      = 4'b1101,
        OP_NE       = 4'b1110,
        OP_SAR      = 4'b1111
    } aluOp_e;

    // Instruction word, most significant field first
    typedef struct packed {
        logic [1:0]  kind;     // Operand arrangement
        logic        storing;  // Memory store, not executed here
        logic        derefRhs; // Memory load, not executed here
        regIndex_t   z;        // Destination
        regIndex_t   x;
        regIndex_t   y;
        aluOp_e      op;
        logic [11:0] imm;      // Sign extended before use
    } insn_t;

    // Instruction queue depth, also the initial input credit count
    localparam int INSN_DEPTH = 4;

    // Results the core may emit before a credit comes back
    localparam int RESULT_CREDITS = 2;

    // Width of the result credit counter
    localparam int CREDIT_W = $clog2(RESULT_CREDITS + 1);

    // Cycles from issue to multiplier done
    localparam int MUL_LATENCY = 3;

    // Program counter register
    localparam regIndex_t REG_P = 4'd15;

endpackage

/* common/operandIf.sv */
`timescale 1ns/1ns

// One issued operation, from the operand shuffle to both execute units
interface operandIf;
    import coreTypes::*;

    logic   valid; // Single cycle issue pulse
    aluOp_e op;
    word_t  a;
    word_t  b;
    word_t  c;     // Addend applied after the operation

    modport source (
        output valid,
        output op,
        output a,
        output b,
        output c
    );

    // Each unit decides from op whether the issue is its own
    modport sink (
        input valid,
        input op,
        input a,
        input b,
        input c
    );

endinterface

/* design/insnQueue.sv */
`timescale 1ns/1ns

module insnQueue #(
    parameter int DEPTH = coreTypes::INSN_DEPTH
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             push,
    input  coreTypes::insn_t pushData,
    input  logic             pop,
    output logic             empty,
    output coreTypes::insn_t headData,
    output logic             credit
);
    import coreTypes::*;

    insn_t                          storage [DEPTH];
    logic [$clog2(DEPTH)-1:0]       readPtr;
    logic [$clog2(DEPTH)-1:0]       writePtr;
    logic [$clog2(DEPTH + 1)-1:0]   count;
    logic                           doPush;
    logic                           doPop;

    assign empty    = (count == '0);
    assign headData = storage[readPtr];
    assign doPop    = pop && !empty;
    assign doPush   = push && ((count != DEPTH) || doPop); // Sender holds a credit anyway
    assign credit   = doPop; // One credit back per instruction taken

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            readPtr  <= '0;
            writePtr <= '0;
            count    <= '0;
        end else begin
            if (doPush)
                writePtr <= (writePtr == DEPTH - 1) ? '0 : writePtr + 1'b1;
            if (doPop)
                readPtr <= (readPtr == DEPTH - 1) ? '0 : readPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush)
            storage[writePtr] <= pushData;
    end

endmodule

/* design/registerFile.sv */
`timescale 1ns/1ns

module registerFile (
    input  logic                 clk,
    input  logic                 reset_n,
    input  coreTypes::regIndex_t indexX,
    input  coreTypes::regIndex_t indexY,
    input  coreTypes::regIndex_t indexZ,
    output coreTypes::word_t     valueX,
    output coreTypes::word_t     valueY,
    output coreTypes::word_t     valueZ,
    input  coreTypes::word_t     nextPc,
    input  logic                 writeEnable,
    input  coreTypes::regIndex_t writeIndex,
    input  coreTypes::word_t     writeValue
);
    import coreTypes::*;

    word_t regs [1:14]; // r0 and P have no storage here

    function automatic word_t readPort(regIndex_t index);
        if (index == '0)
            return '0;
        if (index == REG_P)
            return nextPc; // Address of the current instruction plus one
        return regs[index];
    endfunction

    always_comb begin
        valueX = readPort(indexX);
        valueY = readPort(indexY);
        valueZ = readPort(indexZ);
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i < REG_P; i++)
                regs[i] <= '0;
        end else if (writeEnable && (writeIndex != '0) && (writeIndex != REG_P)) begin
            regs[writeIndex] <= writeValue;
        end
    end

endmodule

/* execute/operandShuffle.sv */
`timescale 1ns/1ns

module operandShuffle (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start,
    input  logic [1:0]        kind,
    input  coreTypes::aluOp_e op,
    input  coreTypes::word_t  valueX,
    input  coreTypes::word_t  valueY,
    input  logic [11:0]       imm,
    operandIf.source          issue
);
    import coreTypes::*;

    word_t immExt; // J

    assign immExt = {{20{imm[11]}}, imm};

    // Issue pulse follows start by one cycle
    always_ff @(posedge clk) begin
        if (!reset_n)
            issue.valid <= 1'b0;
        else
            issue.valid <= start;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            issue.op <= op;
            case (kind)
                2'd1: begin
                    issue.a <= valueX;
                    issue.b <= immExt;
                    issue.c <= valueY;
                end
                2'd2: begin
                    issue.a <= immExt; // Immediate on the left
                    issue.b <= valueX;
                    issue.c <= valueY;
                end
                default: begin // Kind 0, and kind 3 behaves the same
                    issue.a <= valueX;
                    issue.b <= valueY;
                    issue.c <= immExt;
                end
            endcase
        end
    end

endmodule

/* execute/fastAlu.sv */
`timescale 1ns/1ns

module fastAlu (
    input  logic             clk,
    input  logic             reset_n,
    operandIf.sink           issue,
    output logic             done,
    output coreTypes::word_t value
);
    import coreTypes::*;

    word_t opResult;
    logic  take;

    assign take = issue.valid && (issue.op != OP_MUL);

    // Comparisons are signed and yield all ones for true
    always_comb begin
        case (issue.op)
            OP_OR:   opResult = issue.a | issue.b;
            OP_AND:  opResult = issue.a & issue.b;
            OP_ADD:  opResult = issue.a + issue.b;
            OP_SHL:  opResult = issue.a << issue.b; // Full B, 32 and up clears
            OP_LT:   opResult = {32{$signed(issue.a) < $signed(issue.b)}};
            OP_EQ:   opResult = {32{issue.a == issue.b}};
            OP_GE:   opResult = {32{$signed(issue.a) >= $signed(issue.b)}};
            OP_ANDN: opResult = issue.a & ~issue.b;
            OP_XOR:  opResult = issue.a ^ issue.b;
            OP_SUB:  opResult = issue.a - issue.b;
            OP_XNOR: opResult = issue.a ~^ issue.b;
            OP_SHR:  opResult = issue.a >> issue.b;
            OP_NE:   opResult = {32{issue.a != issue.b}};
            OP_SAR:  opResult = $signed(issue.a) >>> issue.b; // Large B gives sign fill
            default: opResult = '0; // Reserved leaves only C, multiply goes elsewhere
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n)
            done <= 1'b0;
        else
            done <= take;
    end

    always_ff @(posedge clk) begin
        if (take)
            value <= opResult + issue.c;
    end

endmodule

/* execute/multiplier.sv */
`timescale 1ns/1ns

module multiplier (
    input  logic             clk,
    input  logic             reset_n,
    operandIf.sink           issue,
    output logic             done,
    output coreTypes::word_t value
);
    import coreTypes::*;

    logic [MUL_LATENCY-1:0] stageValid; // One bit per stage in flight
    word_t                  stage1A;
    word_t                  stage1B;
    word_t                  stage1C;
    word_t                  stage2Product;
    word_t                  stage2C;

    always_ff @(posedge clk) begin
        if (!reset_n)
            stageValid <= '0;
        else
            stageValid <= {stageValid[MUL_LATENCY-2:0], issue.valid && (issue.op == OP_MUL)};
    end

    assign done = stageValid[MUL_LATENCY-1];

    always_ff @(posedge clk) begin
        // Capture operands
        if (issue.valid && (issue.op == OP_MUL)) begin
            stage1A <= issue.a;
            stage1B <= issue.b;
            stage1C <= issue.c;
        end
        if (stageValid[0]) begin
            stage2Product <= stage1A * stage1B; // Low half of the product only
            stage2C       <= stage1C;
        end
        // Add C last
        if (stageValid[1])
            value <= stage2Product + stage2C;
    end

endmodule

/* design/commitSequencer.sv */
`timescale 1ns/1ns

module commitSequencer (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 empty,
    input  coreTypes::insn_t     head,
    output logic                 pop,
    output coreTypes::regIndex_t indexX,
    output coreTypes::regIndex_t indexY,
    output coreTypes::regIndex_t indexZ,
    output logic                 start,
    output logic [1:0]           kind,
    output coreTypes::aluOp_e    op,
    output logic [11:0]          imm,
    input  logic                 aluDone,
    input  coreTypes::word_t     aluValue,
    input  logic                 mulDone,
    input  coreTypes::word_t     mulValue,
    output coreTypes::word_t     nextPc,
    output logic                 writeEnable,
    output coreTypes::regIndex_t writeIndex,
    output coreTypes::word_t     writeValue,
    input  logic                 resultCredit,
    output logic                 resultValid,
    output coreTypes::regIndex_t resultIndex,
    output coreTypes::word_t     resultValue
);
    import coreTypes::*;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        EXECUTE,
        COMMIT,
        STALL
    } state_e;

    state_e              state;
    insn_t               current; // Instruction in flight
    word_t               result;  // Captured unit output
    word_t               pc;
    logic [CREDIT_W-1:0] credits;
    logic                fire;

    assign pop    = (state == IDLE) && !empty;
    assign start  = (state == READ); // Register values have settled by now
    assign indexX = current.x;
    assign indexY = current.y;
    assign indexZ = current.z;
    assign kind   = current.kind;
    assign op     = current.op;
    assign imm    = current.imm;
    assign nextPc = pc + 32'd1;

    // Commit needs a result credit
    assign fire        = ((state == COMMIT) || (state == STALL)) && (credits != '0);
    assign writeEnable = fire; // r0 and P are filtered by the register file
    assign writeIndex  = current.z;
    assign writeValue  = result;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (!empty) state <= READ;
                READ:    state <= EXECUTE;
                EXECUTE: if (aluDone || mulDone) state <= COMMIT;
                COMMIT:  state <= fire ? IDLE : STALL;
                STALL:   if (fire) state <= IDLE; // Waiting on the consumer
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc          <= '0;
            credits     <= CREDIT_W'(RESULT_CREDITS);
            resultValid <= 1'b0;
        end else begin
            resultValid <= fire;
            if (fire)
                pc <= (current.z == REG_P) ? result : nextPc; // Jump or fall through
            case ({resultCredit, fire})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            current <= head;
        if (state == EXECUTE) begin
            if (aluDone)
                result <= aluValue;
            else if (mulDone)
                result <= mulValue;
        end
        if (fire) begin
            resultIndex <= current.z;
            resultValue <= result;
        end
    end

endmodule

/* design/operateCore.sv */
`timescale 1ns/1ns

module operateCore (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 insnValid,
    input  coreTypes::insn_t     insn,
    output logic                 insnCredit,
    output logic                 resultValid,
    output coreTypes::regIndex_t resultIndex,
    output coreTypes::word_t     resultValue,
    input  logic                 resultCredit
);
    import coreTypes::*;

    insn_t       headInsn;
    logic        queueEmpty;
    logic        popInsn;
    regIndex_t   indexX;
    regIndex_t   indexY;
    regIndex_t   indexZ;
    word_t       valueX;
    word_t       valueY;
    word_t       nextPc;
    logic        start;
    logic [1:0]  kind;
    aluOp_e      op;
    logic [11:0] imm;
    logic        aluDone;
    word_t       aluValue;
    logic        mulDone;
    word_t       mulValue;
    logic        writeEnable;
    regIndex_t   writeIndex;
    word_t       writeValue;

    operandIf issueBus ();

    insnQueue #(.DEPTH(INSN_DEPTH)) insnQueue_i (
        .clk(clk), .reset_n(reset_n), .push(insnValid), .pushData(insn),
        .pop(popInsn), .empty(queueEmpty), .headData(headInsn), .credit(insnCredit)
    );

    registerFile registerFile_i (
        .clk(clk), .reset_n(reset_n), .indexX(indexX), .indexY(indexY), .indexZ(indexZ),
        .valueX(valueX), .valueY(valueY), .valueZ(), .nextPc(nextPc),
        .writeEnable(writeEnable), .writeIndex(writeIndex), .writeValue(writeValue)
    );

    operandShuffle operandShuffle_i (
        .clk(clk), .reset_n(reset_n), .start(start), .kind(kind), .op(op),
        .valueX(valueX), .valueY(valueY), .imm(imm), .issue(issueBus.source)
    );

    fastAlu fastAlu_i (
        .clk(clk), .reset_n(reset_n), .issue(issueBus.sink), .done(aluDone), .value(aluValue)
    );

    multiplier multiplier_i (
        .clk(clk), .reset_n(reset_n), .issue(issueBus.sink), .done(mulDone), .value(mulValue)
    );

    commitSequencer commitSequencer_i (
        .clk(clk), .reset_n(reset_n), .empty(queueEmpty), .head(headInsn), .pop(popInsn),
        .indexX(indexX), .indexY(indexY), .indexZ(indexZ), .start(start), .kind(kind),
        .op(op), .imm(imm), .aluDone(aluDone), .aluValue(aluValue), .mulDone(mulDone),
        .mulValue(mulValue), .nextPc(nextPc), .writeEnable(writeEnable),
        .writeIndex(writeIndex), .writeValue(writeValue), .resultCredit(resultCredit),
        .resultValid(resultValid), .resultIndex(resultIndex), .resultValue(resultValue)
    );

endmodule

/* verification/coreModel.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Model state, r0 and P are never read from modelRegs
word_t       modelRegs [16];
word_t       modelPc;
logic [31:0] lfsrState = 32'h13774e1a;

function automatic void resetModel();
    foreach (modelRegs[n])
        modelRegs[n] = '0;
    modelPc = '0;
endfunction

function automatic word_t readReg(input regIndex_t index);
    if (index == 4'd0)
        return '0;
    if (index == 4'd15)
        return modelPc + 32'd1; // This instruction's address plus one
    return modelRegs[index];
endfunction

// Runs one instruction on the model and returns the value written to Z
function automatic word_t expectedResult(input insn_t i);
    word_t              x;
    word_t              y;
    word_t              j;
    word_t              a;
    word_t              b;
    word_t              c;
    word_t              r;
    logic signed [31:0] signedA;
    x = readReg(i.x);
    y = readReg(i.y);
    j = {{20{i.imm[11]}}, i.imm};
    a = (i.kind == 2'd2) ? j : x;
    b = (i.kind == 2'd1) ? j : ((i.kind == 2'd2) ? x : y);
    c = ((i.kind == 2'd1) || (i.kind == 2'd2)) ? y : j; // Kind 3 as kind 0
    signedA = a;
    case (i.op)
        OP_OR:   r = a | b;
        OP_AND:  r = a & b;
        OP_ADD:  r = a + b;
        OP_MUL:  r = a * b; // Low word
        OP_SHL:  r = (b > 32'd31) ? '0 : (a << b[4:0]);
        OP_LT:   r = {32{$signed(a) < $signed(b)}};
        OP_EQ:   r = {32{a == b}};
        OP_GE:   r = {32{$signed(a) >= $signed(b)}};
        OP_ANDN: r = a & ~b;
        OP_XOR:  r = a ^ b;
        OP_SUB:  r = a - b;
        OP_XNOR: r = ~(a ^ b);
        OP_SHR:  r = (b > 32'd31) ? '0 : (a >> b[4:0]);
        OP_NE:   r = {32{a != b}};
        OP_SAR: begin
            if (b > 32'd31)
                r = {32{a[31]}};
            else
                r = signedA >>> b[4:0];
        end
        default: r = '0; // Reserved
    endcase
    r = r + c;
    if (i.z == 4'd15) begin
        modelPc = r; // Jump
    end else begin
        modelPc = modelPc + 32'd1;
        if (i.z != 4'd0)
            modelRegs[i.z] = r;
    end
    return r;
endfunction

// Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic nextLfsrBit();
    logic feedback;
    feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], feedback};
    return feedback;
endfunction

function automatic logic [31:0] randomBits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int n = 0; n < count; n++)
        bits = {bits[30:0], nextLfsrBit()};
    return bits;
endfunction

`endif

/* verification/operateCoreTb.sv */
`timescale 1ns/1ns

module operateCoreTb;
    import coreTypes::*;

    `include "coreModel.svh"

    localparam int PAIR_COUNT    = 8;
    localparam int DELAYED_COUNT = 30;
    localparam int RANDOM_COUNT  = 200;
    // Directed lists with two edge forms per op and pair plus the random runs
    localparam int TOTAL_INSNS   = 40 + 32 * PAIR_COUNT + DELAYED_COUNT + RANDOM_COUNT;
    localparam regIndex_t PAIR_X [PAIR_COUNT] = '{4'd6, 4'd10, 4'd8, 4'd3, 4'd6, 4'd6, 4'd8, 4'd1};
    localparam regIndex_t PAIR_Y [PAIR_COUNT] = '{4'd10, 4'd6, 4'd3, 4'd8, 4'd6, 4'd7, 4'd9, 4'd2};

    logic      clk = 1'b0;
    logic      reset_n;
    logic      insnValid;
    insn_t     insn;
    logic      insnCredit;
    logic      resultValid;
    regIndex_t resultIndex;
    word_t     resultValue;
    logic      resultCredit = 1'b0;
    insn_t     sentQ [$];        // Sent and not yet reported in send order
    int        creditDelays [$]; // Cycles to wait before each credit goes back
    int        inCredits = 0;
    int        outCredits = 0;
    logic      longDelays = 1'b0;
    int        checked = 0;
    int        indexErrors = 0;
    int        valueErrors = 0;
    int        creditErrors = 0;

    operateCore operateCore_i (
        .clk(clk), .reset_n(reset_n), .insnValid(insnValid), .insn(insn),
        .insnCredit(insnCredit), .resultValid(resultValid), .resultIndex(resultIndex),
        .resultValue(resultValue), .resultCredit(resultCredit)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (!reset_n) begin
            inCredits  <= INSN_DEPTH;
            outCredits <= RESULT_CREDITS;
        end else begin
            inCredits  <= inCredits + (insnCredit ? 1 : 0) - (insnValid ? 1 : 0);
            outCredits <= outCredits + (resultCredit ? 1 : 0) - (resultValid ? 1 : 0);
        end
    end

    always @(posedge clk) begin
        insn_t oldest;
        word_t expValue;
        if (reset_n && insnCredit) begin
            assert (inCredits < INSN_DEPTH) else begin
                $display("Input credit returned at %0t with no instruction queued", $time);
                creditErrors++;
            end
        end
        if (reset_n && resultValid) begin
            assert (outCredits > 0) else begin
                $display("Result emitted at %0t without a result credit", $time);
                creditErrors++;
            end
            creditDelays.push_back(longDelays ? int'(randomBits(5)) : int'(randomBits(2)));
            assert (sentQ.size() != 0) else begin
                $display("Result at %0t with no instruction outstanding", $time);
                indexErrors++;
            end
            if (sentQ.size() != 0) begin
                oldest   = sentQ.pop_front();
                expValue = expectedResult(oldest);
                checked++;
                assert (resultIndex == oldest.z) else begin
                    $display("FAIL %0t: result index %0d, expected %0d",
                             $time, resultIndex, oldest.z);
                    indexErrors++;
                end
                assert (resultValue == expValue) else begin
                    $display("FAIL %0t: r%0d value %h, expected %h",
                             $time, oldest.z, resultValue, expValue);
                    valueErrors++;
                end
            end
        end
    end

    // Consumer returns a credit once the head delay has run out
    always @(negedge clk) begin
        resultCredit = 1'b0;
        if (creditDelays.size() != 0) begin
            if (creditDelays[0] == 0) begin
                void'(creditDelays.pop_front());
                resultCredit = 1'b1;
            end else begin
                creditDelays[0] = creditDelays[0] - 1;
            end
        end
    end

    task automatic sendInsn(input insn_t i);
        @(negedge clk);
        insnValid = 1'b0;
        while (inCredits == 0)
            @(negedge clk);
        insn      = i;
        insnValid = 1'b1;
        sentQ.push_back(i);
    endtask

    task automatic issueInsn(input logic [1:0] kind, input regIndex_t z, input regIndex_t x,
                             input regIndex_t y, input aluOp_e op, input logic [11:0] imm);
        insn_t i;
        i = '{kind: kind, storing: 1'b0, derefRhs: 1'b0, z: z, x: x, y: y, op: op, imm: imm};
        sendInsn(i);
    endtask

    function automatic insn_t randomInsn();
        insn_t i;
        i.kind     = 2'(randomBits(2));
        i.storing  = randomBits(1) != 0; // Ignored by the core
        i.derefRhs = randomBits(1) != 0;
        i.z        = 4'(randomBits(4));
        i.x        = 4'(randomBits(4));
        i.y        = 4'(randomBits(4));
        i.op       = aluOp_e'(4'(randomBits(4)));
        i.imm      = 12'(randomBits(12));
        return i;
    endfunction

    task automatic drainResults();
        @(negedge clk);
        insnValid = 1'b0;
        while (sentQ.size() != 0)
            @(negedge clk);
    endtask

    initial begin
        reset_n   = 1'b0;
        insnValid = 1'b0;
        insn      = '0;
        resetModel();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        // Operand arrangement per kind with negative immediates
        issueInsn(2'd0, 4'd1, 4'd0, 4'd0, OP_OR, 12'd100);
        issueInsn(2'd0, 4'd2, 4'd0, 4'd0, OP_OR, 12'hFFB); // -5
        for (int k = 0; k < 4; k++) begin
            issueInsn(2'(k), 4'd3, 4'd1, 4'd2, OP_SUB, 12'hFFD);
            issueInsn(2'(k), 4'd4, 4'd1, 4'd2, OP_ADD, 12'h800); // Most negative immediate
        end
        // r6 holds 0x80000000, r10 0x7fffffff, r7 and r9 shift amounts past 31
        issueInsn(2'd0, 4'd3, 4'd0, 4'd0, OP_OR, 12'd1);
        issueInsn(2'd1, 4'd6, 4'd3, 4'd0, OP_SHL, 12'd31);
        issueInsn(2'd0, 4'd7, 4'd0, 4'd0, OP_OR, 12'd32);
        issueInsn(2'd0, 4'd8, 4'd0, 4'd0, OP_OR, 12'hFFF);
        issueInsn(2'd0, 4'd9, 4'd0, 4'd0, OP_OR, 12'd33);
        issueInsn(2'd0, 4'd10, 4'd6, 4'd8, OP_ADD, 12'd0);
        for (int op = 0; op < 16; op++) begin
            for (int p = 0; p < PAIR_COUNT; p++) begin
                issueInsn(2'd0, 4'd11, PAIR_X[p], PAIR_Y[p], aluOp_e'(op[3:0]), 12'd0);
                issueInsn(2'd1, 4'd12, PAIR_X[p], PAIR_Y[p], aluOp_e'(op[3:0]), 12'd40);
            end
        end
        drainResults();
        issueInsn(2'd0, 4'd11, 4'd1, 4'd2, OP_MUL, 12'd7); // Multiply on its own
        drainResults();
        issueInsn(2'd0, 4'd11, 4'd1, 4'd1, OP_MUL, 12'd5);
        issueInsn(2'd0, 4'd12, 4'd11, 4'd2, OP_ADD, 12'd0);
        issueInsn(2'd1, 4'd13, 4'd11, 4'd12, OP_MUL, 12'h9C4);
        issueInsn(2'd2, 4'd11, 4'd13, 4'd1, OP_SUB, 12'd3);
        issueInsn(2'd0, 4'd14, 4'd6, 4'd8, OP_MUL, 12'd0);
        issueInsn(2'd2, 4'd14, 4'd14, 4'd10, OP_MUL, 12'hFFE);
        issueInsn(2'd0, 4'd12, 4'd14, 4'd13, OP_XOR, 12'd0);
        // r0 stays zero and P reads around two jumps
        issueInsn(2'd0, 4'd0, 4'd1, 4'd2, OP_ADD, 12'd55);
        issueInsn(2'd0, 4'd5, 4'd0, 4'd0, OP_OR, 12'd0);
        issueInsn(2'd0, 4'd5, 4'd15, 4'd0, OP_OR, 12'd0);
        issueInsn(2'd0, 4'd15, 4'd0, 4'd0, OP_OR, 12'h100);
        issueInsn(2'd0, 4'd5, 4'd15, 4'd0, OP_OR, 12'd0);
        issueInsn(2'd2, 4'd15, 4'd15, 4'd0, OP_ADD, 12'hFF0); // Backward jump
        issueInsn(2'd1, 4'd5, 4'd15, 4'd0, OP_ADD, 12'd0);
        drainResults();
        longDelays = 1'b1; // Slow consumer
        repeat (DELAYED_COUNT) sendInsn(randomInsn());
        drainResults();
        longDelays = 1'b0;
        repeat (RANDOM_COUNT) sendInsn(randomInsn());
        drainResults();
        repeat (4) @(negedge clk);
        $display("Checked %0d results: %0d index errors, %0d value errors, %0d credit errors",
                 checked, indexErrors, valueErrors, creditErrors);
        if (indexErrors + valueErrors + creditErrors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        repeat (TOTAL_INSNS * 20 + 100) @(posedge clk);
        $display("Timeout after %0d cycles, %0d results still missing",
                 TOTAL_INSNS * 20 + 100, sentQ.size());
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* build.f */
+incdir+verification
common/coreTypes.sv
common/operandIf.sv
design/insnQueue.sv
design/registerFile.sv
execute/operandShuffle.sv
execute/fastAlu.sv
execute/multiplier.sv
design/commitSequencer.sv
design/operateCore.sv
verification/operateCoreTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the operateCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module operateCoreTb -f build.f; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/VoperateCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
